/* verilog/enigma_macros.svh */
`ifndef ENIGMA_MACROS_SVH
`define ENIGMA_MACROS_SVH

// letters on the keyboard and on each rotor
`define ALPHA_SIZE 26

// bits needed for a letter index 0..25
`define LETTER_W 5

// set 2 break prefix, the next byte names the released key
`define SCAN_BREAK 8'hF0

// ascii code of letter A, cipher index 0 maps here
`define ASCII_A 8'h41

`endif

/* verilog/enigma_pkg.sv */
`default_nettype none

`include "enigma_macros.svh"

package enigma_pkg;

    // letter index, A = 0 .. Z = 25
    typedef logic [`LETTER_W-1:0] letter_t;

    // ascii byte of one cipher letter
    typedef logic [7:0] ascii_t;

    // one decoded key press
    typedef struct packed {
        letter_t letter;
    } key_event_t;

    // window letters of the three rotors
    // left is rotor I, middle rotor II, right rotor III
    typedef struct packed {
        letter_t left;
        letter_t middle;
        letter_t right;
    } rotor_pos_t;

    // plaintext letter with the positions it is enciphered at
    typedef struct packed {
        letter_t    letter;
        rotor_pos_t pos;
    } step_item_t;

endpackage

`default_nettype wire

/* verilog/scan_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "enigma_macros.svh"

module scan_decoder (
    input  logic                   CLOCK_50,
    input  logic                   i_reset,
    input  logic [7:0]             i_scan_byte,
    input  logic                   i_scan_valid,
    output enigma_pkg::key_event_t o_key,
    output logic                   o_key_valid,
    input  logic                   i_key_ready
);

    import enigma_pkg::*;

    // make/break framing
    // ST_BREAK means the next byte names a released key
    typedef enum logic {
        ST_IDLE,
        ST_BREAK
    } dec_state_t;

    dec_state_t state_q;
    logic       is_letter;
    letter_t    scan_letter;
    logic       take_key;

    // set 2 scan codes of the letter keys
    always_comb begin
        is_letter   = 1'b1;
        scan_letter = '0;
        case (i_scan_byte)
            8'h1C: scan_letter = 5'd0;
            8'h32: scan_letter = 5'd1;
            8'h21: scan_letter = 5'd2;
            8'h23: scan_letter = 5'd3;
            8'h24: scan_letter = 5'd4;
            8'h2B: scan_letter = 5'd5;
            8'h34: scan_letter = 5'd6;
            8'h33: scan_letter = 5'd7;
            8'h43: scan_letter = 5'd8;
            8'h3B: scan_letter = 5'd9;
            8'h42: scan_letter = 5'd10;
            8'h4B: scan_letter = 5'd11;
            8'h3A: scan_letter = 5'd12;
            8'h31: scan_letter = 5'd13;
            8'h44: scan_letter = 5'd14;
            8'h4D: scan_letter = 5'd15;
            8'h15: scan_letter = 5'd16;
            8'h2D: scan_letter = 5'd17;
            8'h1B: scan_letter = 5'd18;
            8'h2C: scan_letter = 5'd19;
            8'h3C: scan_letter = 5'd20;
            8'h2A: scan_letter = 5'd21;
            8'h1D: scan_letter = 5'd22;
            8'h22: scan_letter = 5'd23;
            8'h35: scan_letter = 5'd24;
            8'h1A: scan_letter = 5'd25;
            default: is_letter = 1'b0;
        endcase
    end

    // a letter make becomes an event only if the slot is free
    // or the pending event leaves this same cycle
    // otherwise the key is lost, the keyboard cannot wait
    assign take_key = i_scan_valid && is_letter && (state_q == ST_IDLE)
                      && (!o_key_valid || i_key_ready);

    always_ff @(posedge CLOCK_50) begin
        if (i_reset) begin
            state_q     <= ST_IDLE;
            o_key_valid <= 1'b0;
        end else begin
            // pending event handed to the stepper
            if (o_key_valid && i_key_ready) begin
                o_key_valid <= 1'b0;
            end
            if (take_key) begin
                o_key_valid <= 1'b1;
            end

            if (i_scan_valid) begin
                if (state_q == ST_BREAK) begin
                    // released key code, never an event
                    state_q <= ST_IDLE;
                end else if (i_scan_byte == `SCAN_BREAK) begin
                    state_q <= ST_BREAK;
                end
                // make codes leave the framing untouched
            end
        end
    end

    // event payload
    always_ff @(posedge CLOCK_50) begin
        if (take_key) begin
            o_key.letter <= scan_letter;
        end
    end

endmodule

`default_nettype wire

/* verilog/rotor_stepper.sv */
`default_nettype none
`timescale 1ns/10ps

`include "enigma_macros.svh"

module rotor_stepper (
    input  logic                   CLOCK_50,
    input  logic                   i_reset,
    input  enigma_pkg::key_event_t i_key,
    input  logic                   i_key_valid,
    output logic                   o_key_ready,
    input  logic                   i_load,
    input  enigma_pkg::rotor_pos_t i_start_pos,
    output enigma_pkg::step_item_t o_item,
    output logic                   o_item_valid,
    input  logic                   i_item_ready,
    output enigma_pkg::rotor_pos_t o_positions
);

    import enigma_pkg::*;

    localparam letter_t LAST_LETTER = letter_t'(`ALPHA_SIZE - 1);
    // turnover letters, rings all at A
    // rotor II turns its neighbour leaving E
    localparam letter_t NOTCH_II = 5'd4;
    // rotor III leaving V
    localparam letter_t NOTCH_III = 5'd21;

    rotor_pos_t pos_q;
    rotor_pos_t pos_step;
    logic       step_mid;
    logic       step_left;
    logic       key_fire;

    // one position forward, Z wraps to A
    function automatic letter_t next_letter(input letter_t v);
        return (v == LAST_LETTER) ? letter_t'(0) : letter_t'(v + 1'b1);
    endfunction

    // pawls look at the positions before the key moves them
    always_comb begin
        step_left = (pos_q.middle == NOTCH_II);
        // middle at its own notch steps again, the double step
        step_mid  = (pos_q.right == NOTCH_III) || step_left;

        pos_step.right  = next_letter(pos_q.right);
        pos_step.middle = step_mid ? next_letter(pos_q.middle) : pos_q.middle;
        pos_step.left   = step_left ? next_letter(pos_q.left) : pos_q.left;
    end

    // single slot, free when empty or draining
    assign o_key_ready = !o_item_valid || i_item_ready;
    assign key_fire    = i_key_valid && o_key_ready;

    always_ff @(posedge CLOCK_50) begin
        if (i_reset) begin
            pos_q        <= '0;
            o_item_valid <= 1'b0;
        end else begin
            // start position load wins over a key
            if (i_load) begin
                pos_q <= i_start_pos;
            end else if (key_fire) begin
                pos_q <= pos_step;
            end

            if (key_fire) begin
                o_item_valid <= 1'b1;
            end else if (i_item_ready) begin
                o_item_valid <= 1'b0;
            end
        end
    end

    // letter goes on with the stepped positions
    always_ff @(posedge CLOCK_50) begin
        if (key_fire) begin
            o_item.letter <= i_key.letter;
            o_item.pos    <= pos_step;
        end
    end

    assign o_positions = pos_q;

endmodule

`default_nettype wire

/* verilog/rotor_path.sv */
`default_nettype none
`timescale 1ns/10ps

`include "enigma_macros.svh"

module rotor_path (
    input  logic                   CLOCK_50,
    input  logic                   i_reset,
    input  enigma_pkg::step_item_t i_item,
    input  logic                   i_item_valid,
    output logic                   o_item_ready,
    output enigma_pkg::letter_t    o_cipher,
    output logic                   o_cipher_valid,
    input  logic                   i_cipher_ready
);

    import enigma_pkg::*;

    localparam logic [`LETTER_W:0] ALPHA = `ALPHA_SIZE;

    // rotor I, EKMFLGDQVZNTOWYHXUSPAIBRCJ
    localparam letter_t FWD_I [`ALPHA_SIZE] = '{
        5'd4,  5'd10, 5'd12, 5'd5,  5'd11, 5'd6,  5'd3,  5'd16, 5'd21, 5'd25,
        5'd13, 5'd19, 5'd14, 5'd22, 5'd24, 5'd7,  5'd23, 5'd20, 5'd18, 5'd15,
        5'd0,  5'd8,  5'd1,  5'd17, 5'd2,  5'd9};
    localparam letter_t INV_I [`ALPHA_SIZE] = '{
        5'd20, 5'd22, 5'd24, 5'd6,  5'd0,  5'd3,  5'd5,  5'd15, 5'd21, 5'd25,
        5'd1,  5'd4,  5'd2,  5'd10, 5'd12, 5'd19, 5'd7,  5'd23, 5'd18, 5'd11,
        5'd17, 5'd8,  5'd13, 5'd16, 5'd14, 5'd9};
    // rotor II, AJDKSIRUXBLHWTMCQGZNPYFVOE
    localparam letter_t FWD_II [`ALPHA_SIZE] = '{
        5'd0,  5'd9,  5'd3,  5'd10, 5'd18, 5'd8,  5'd17, 5'd20, 5'd23, 5'd1,
        5'd11, 5'd7,  5'd22, 5'd19, 5'd12, 5'd2,  5'd16, 5'd6,  5'd25, 5'd13,
        5'd15, 5'd24, 5'd5,  5'd21, 5'd14, 5'd4};
    localparam letter_t INV_II [`ALPHA_SIZE] = '{
        5'd0,  5'd9,  5'd15, 5'd2,  5'd25, 5'd22, 5'd17, 5'd11, 5'd5,  5'd1,
        5'd3,  5'd10, 5'd14, 5'd19, 5'd24, 5'd20, 5'd16, 5'd6,  5'd4,  5'd13,
        5'd7,  5'd23, 5'd12, 5'd8,  5'd21, 5'd18};
    // rotor III, BDFHJLCPRTXVZNYEIWGAKMUSQO
    localparam letter_t FWD_III [`ALPHA_SIZE] = '{
        5'd1,  5'd3,  5'd5,  5'd7,  5'd9,  5'd11, 5'd2,  5'd15, 5'd17, 5'd19,
        5'd23, 5'd21, 5'd25, 5'd13, 5'd24, 5'd4,  5'd8,  5'd22, 5'd6,  5'd0,
        5'd10, 5'd12, 5'd20, 5'd18, 5'd16, 5'd14};
    localparam letter_t INV_III [`ALPHA_SIZE] = '{
        5'd19, 5'd0,  5'd6,  5'd1,  5'd15, 5'd2,  5'd18, 5'd3,  5'd16, 5'd4,
        5'd20, 5'd5,  5'd21, 5'd13, 5'd25, 5'd7,  5'd24, 5'd8,  5'd23, 5'd9,
        5'd22, 5'd11, 5'd17, 5'd10, 5'd14, 5'd12};
    // reflector B, YRUHQSLDPXNGOKMIEBFZCWVJAT
    localparam letter_t REFL_B [`ALPHA_SIZE] = '{
        5'd24, 5'd17, 5'd20, 5'd7,  5'd16, 5'd18, 5'd11, 5'd3,  5'd15, 5'd23,
        5'd13, 5'd6,  5'd14, 5'd10, 5'd12, 5'd8,  5'd4,  5'd1,  5'd5,  5'd25,
        5'd2,  5'd22, 5'd21, 5'd9,  5'd0,  5'd19};

    letter_t fwd_right;
    letter_t fwd_mid;
    letter_t fwd_left;
    letter_t reflected;
    letter_t back_left;
    letter_t back_mid;
    letter_t back_right;
    logic    item_fire;

    // (a + b) mod 26
    function automatic letter_t add_mod(input letter_t a, input letter_t b);
        logic [`LETTER_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= ALPHA) begin
            sum = sum - ALPHA;
        end
        return sum[`LETTER_W-1:0];
    endfunction

    // (a - b) mod 26
    function automatic letter_t sub_mod(input letter_t a, input letter_t b);
        logic [`LETTER_W:0] diff;
        diff = {1'b0, a} + ALPHA - {1'b0, b};
        if (diff >= ALPHA) begin
            diff = diff - ALPHA;
        end
        return diff[`LETTER_W-1:0];
    endfunction

    // each rotor: shift in by its position, wire, shift back out
    always_comb begin
        // inbound, right to left
        fwd_right = sub_mod(FWD_III[add_mod(i_item.letter, i_item.pos.right)],
                            i_item.pos.right);
        fwd_mid   = sub_mod(FWD_II[add_mod(fwd_right, i_item.pos.middle)],
                            i_item.pos.middle);
        fwd_left  = sub_mod(FWD_I[add_mod(fwd_mid, i_item.pos.left)], i_item.pos.left);
        // reflector does not turn
        reflected = REFL_B[fwd_left];
        // return path on the inverse wirings, left to right
        back_left  = sub_mod(INV_I[add_mod(reflected, i_item.pos.left)], i_item.pos.left);
        back_mid   = sub_mod(INV_II[add_mod(back_left, i_item.pos.middle)],
                             i_item.pos.middle);
        back_right = sub_mod(INV_III[add_mod(back_mid, i_item.pos.right)],
                             i_item.pos.right);
    end

    assign o_item_ready = !o_cipher_valid || i_cipher_ready;
    assign item_fire    = i_item_valid && o_item_ready;

    always_ff @(posedge CLOCK_50) begin
        if (i_reset) begin
            o_cipher_valid <= 1'b0;
        end else if (item_fire) begin
            o_cipher_valid <= 1'b1;
        end else if (i_cipher_ready) begin
            o_cipher_valid <= 1'b0;
        end
    end

    // cipher letter register
    always_ff @(posedge CLOCK_50) begin
        if (item_fire) begin
            o_cipher <= back_right;
        end
    end

endmodule

`default_nettype wire

/* verilog/cipher_result.sv */
`default_nettype none
`timescale 1ns/10ps

`include "enigma_macros.svh"

module cipher_result (
    input  logic                CLOCK_50,
    input  logic                i_reset,
    input  enigma_pkg::letter_t i_cipher,
    input  logic                i_cipher_valid,
    output logic                o_cipher_ready,
    output enigma_pkg::ascii_t  o_ascii,
    output logic                o_valid,
    input  logic                i_ready
);

    import enigma_pkg::*;

    logic cipher_fire;

    // output register takes a new letter only when empty or being read
    // so o_ascii holds steady while the sink stalls
    assign o_cipher_ready = !o_valid || i_ready;
    assign cipher_fire    = i_cipher_valid && o_cipher_ready;

    always_ff @(posedge CLOCK_50) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (cipher_fire) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // index 0..25 to upper case ascii
    always_ff @(posedge CLOCK_50) begin
        if (cipher_fire) begin
            o_ascii <= ascii_t'(i_cipher) + `ASCII_A;
        end
    end

endmodule

`default_nettype wire

/* verilog/enigma_top.sv */
`default_nettype none
`timescale 1ns/10ps

module enigma_top (
    input  logic                   CLOCK_50,
    input  logic                   i_reset,
    input  logic [7:0]             i_scan_byte,
    input  logic                   i_scan_valid,
    input  logic                   i_load,
    input  enigma_pkg::rotor_pos_t i_start_pos,
    output enigma_pkg::ascii_t     o_ascii,
    output logic                   o_valid,
    input  logic                   i_ready,
    output enigma_pkg::rotor_pos_t o_positions
);

    // decoder to stepper
    enigma_pkg::key_event_t key;
    logic                   key_valid;
    logic                   key_ready;
    // stepper to rotor path
    enigma_pkg::step_item_t item;
    logic                   item_valid;
    logic                   item_ready;
    // rotor path to ascii stage
    enigma_pkg::letter_t    cipher;
    logic                   cipher_valid;
    logic                   cipher_ready;

    // keyboard bytes to letter events
    scan_decoder u_decoder (
        .CLOCK_50,
        .i_reset,
        .i_scan_byte,
        .i_scan_valid,
        .o_key       (key),
        .o_key_valid (key_valid),
        .i_key_ready (key_ready)
    );

    // rotor positions, stepping per key
    rotor_stepper u_stepper (
        .CLOCK_50,
        .i_reset,
        .i_key        (key),
        .i_key_valid  (key_valid),
        .o_key_ready  (key_ready),
        .i_load,
        .i_start_pos,
        .o_item       (item),
        .o_item_valid (item_valid),
        .i_item_ready (item_ready),
        .o_positions
    );

    // through the rotors, reflector and back
    rotor_path u_path (
        .CLOCK_50,
        .i_reset,
        .i_item         (item),
        .i_item_valid   (item_valid),
        .o_item_ready   (item_ready),
        .o_cipher       (cipher),
        .o_cipher_valid (cipher_valid),
        .i_cipher_ready (cipher_ready)
    );

    // ciphertext out as ascii
    cipher_result u_result (
        .CLOCK_50,
        .i_reset,
        .i_cipher       (cipher),
        .i_cipher_valid (cipher_valid),
        .o_cipher_ready (cipher_ready),
        .o_ascii,
        .o_valid,
        .i_ready
    );

endmodule

`default_nettype wire

/* verif/enigma_model.svh */
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

// wirings as ascii text, entry contact A first
// 0..2 are rotors I, II, III, 3 is reflector B
localparam logic [8*26-1:0] WIRING_TAB [4] = '{
    "EKMFLGDQVZNTOWYHXUSPAIBRCJ",
    "AJDKSIRUXBLHWTMCQGZNPYFVOE",
    "BDFHJLCPRTXVZNYEIWGAKMUSQO",
    "YRUHQSLDPXNGOKMIEBFZCWVJAT"};

// turnover on leaving E (rotor II) and V (rotor III)
localparam int NOTCH_MID   = 4;
localparam int NOTCH_RIGHT = 21;

// set 2 make codes of A..Z
localparam logic [7:0] SCAN_TAB [26] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
    8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
    8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};

// window letters, 0 left .. 2 right
int model_pos [3];

// contact reached from contact c through one wiring
function automatic int wiring(input int which, input int c);
    return int'(WIRING_TAB[which][8*(25-c) +: 8]) - 65;
endfunction

// one rotor at window letter p, forward or on the way back
function automatic int rotor_pass(input int which, input int c, input int p, input bit back);
    int k;
    int shifted;
    int out;
    shifted = (c + p) % 26;
    out     = wiring(which, shifted);
    if (back) begin
        // inverse by search over the contacts
        for (k = 0; k < 26; k++) begin
            if (wiring(which, k) == shifted) begin
                out = k;
            end
        end
    end
    return (out - p + 26) % 26;
endfunction

// pawls act first, then the letter goes through
task automatic step_and_encipher(input int letter, output int cipher);
    bit turn_left;
    bit turn_mid;
    int c;
    int k;
    turn_left    = (model_pos[1] == NOTCH_MID);
    // middle at its own notch moves again
    turn_mid     = (model_pos[2] == NOTCH_RIGHT) || turn_left;
    model_pos[2] = (model_pos[2] + 1) % 26;
    if (turn_mid) begin
        model_pos[1] = (model_pos[1] + 1) % 26;
    end
    if (turn_left) begin
        model_pos[0] = (model_pos[0] + 1) % 26;
    end
    c = letter;
    for (k = 2; k >= 0; k--) begin
        c = rotor_pass(k, c, model_pos[k], 1'b0);
    end
    c = wiring(3, c);
    for (k = 0; k < 3; k++) begin
        c = rotor_pass(k, c, model_pos[k], 1'b1);
    end
    cipher = c;
endtask

`endif

/* verif/tb_enigma.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_enigma;

    import enigma_pkg::*;

    localparam int CLK_PERIOD = 8;
    // known text, 4 random blocks, notch runs, filter, back-pressure
    localparam int TOTAL_KEYS = 5 + 4 * 30 + 8 + 1 + 40;
    localparam int KEY_CYCLES = 40;
    localparam logic [39:0] KNOWN_TEXT = "BDZGO";

    logic       CLOCK_50;
    logic       i_reset;
    logic [7:0] i_scan_byte;
    logic       i_scan_valid;
    logic       i_load;
    rotor_pos_t i_start_pos;
    ascii_t     o_ascii;
    logic       o_valid;
    logic       i_ready;
    rotor_pos_t o_positions;

    int         errors = 0;
    int         cipher;
    bit         random_ready = 1'b0;
    // ascii bytes taken by the sink
    logic [7:0] got_q [$];

    `include "enigma_model.svh"

    enigma_top UUT (.*);

    initial CLOCK_50 = 1'b0;
    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    // output sink, picks i_ready at each falling edge
    initial begin : sink
        bit         stalled;
        logic [7:0] held;
        stalled = 1'b0;
        held    = 8'h00;
        i_ready = 1'b1;
        forever begin
            @(negedge CLOCK_50);
            // stalled output must hold still
            if (stalled && (o_valid !== 1'b1 || o_ascii !== held)) begin
                $display("MISMATCH stall_hold: expected %c valid 1 got %c valid %b",
                         held, o_ascii, o_valid);
                errors++;
            end
            i_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
            // transfer lands on the coming rising edge
            if (o_valid === 1'b1 && i_ready) begin
                got_q.push_back(o_ascii);
            end
            stalled = (o_valid === 1'b1) && !i_ready;
            held    = o_ascii;
        end
    end

    task automatic send_byte(input logic [7:0] b);
        @(negedge CLOCK_50);
        i_scan_byte  = b;
        i_scan_valid = 1'b1;
        @(negedge CLOCK_50);
        i_scan_valid = 1'b0;
    endtask

    task automatic check_positions(input string test);
        rotor_pos_t exp;
        exp = {letter_t'(model_pos[0]), letter_t'(model_pos[1]), letter_t'(model_pos[2])};
        if (o_positions !== exp) begin
            $display("MISMATCH %s: expected %c%c%c got %c%c%c", test, exp.left + 65,
                     exp.middle + 65, exp.right + 65, o_positions.left + 65,
                     o_positions.middle + 65, o_positions.right + 65);
            errors++;
        end
    endtask

    // only while the pipeline is empty
    task automatic load_start(input int l, input int m, input int r);
        @(negedge CLOCK_50);
        i_load      = 1'b1;
        i_start_pos = {letter_t'(l), letter_t'(m), letter_t'(r)};
        @(negedge CLOCK_50);
        i_load    = 1'b0;
        model_pos = '{l, m, r};
        check_positions("load");
    endtask

    // make, break prefix, break code, then wait for the cipher letter
    task automatic type_key(input string test, input int letter, output int exp);
        int         waited;
        logic [7:0] got;
        step_and_encipher(letter, exp);
        send_byte(SCAN_TAB[letter]);
        send_byte(8'hF0);
        send_byte(SCAN_TAB[letter]);
        waited = 0;
        while (got_q.size() == 0 && waited < KEY_CYCLES) begin
            @(posedge CLOCK_50);
            waited++;
        end
        if (got_q.size() == 0) begin
            $display("%s: no ciphertext came out for key %c", test, letter + 65);
            errors++;
        end else begin
            got = got_q.pop_front();
            if (got !== 8'(exp + 65)) begin
                $display("MISMATCH %s: expected %c got %c", test, exp + 65, got);
                errors++;
            end
        end
        @(negedge CLOCK_50);
        check_positions(test);
    endtask

    initial begin
        void'($urandom(32'h2a4a));
        i_reset      = 1'b1;
        i_scan_byte  = 8'h00;
        i_scan_valid = 1'b0;
        i_load       = 1'b0;
        i_start_pos  = '0;
        model_pos    = '{0, 0, 0};
        repeat (16) @(negedge CLOCK_50);
        i_reset = 1'b0;

        // reset state, then a random load
        @(negedge CLOCK_50);
        check_positions("reset");
        if (o_valid !== 1'b0) begin
            $display("MISMATCH reset_valid: expected 0 got %b", o_valid);
            errors++;
        end
        load_start($urandom % 26, $urandom % 26, $urandom % 26);

        // AAAAA from AAA
        load_start(0, 0, 0);
        for (int i = 0; i < 5; i++) begin
            type_key("known", 0, cipher);
            if (cipher + 65 != KNOWN_TEXT[8*(4-i) +: 8]) begin
                $display("MISMATCH known_model: expected %c got %c",
                         KNOWN_TEXT[8*(4-i) +: 8], cipher + 65);
                errors++;
            end
        end

        for (int b = 0; b < 4; b++) begin
            load_start($urandom % 26, $urandom % 26, $urandom % 26);
            repeat (30) type_key("random", $urandom % 26, cipher);
        end

        // right into V, then the double step; then all three turn at once
        load_start(0, 3, 20);
        repeat (4) type_key("notch_adu", $urandom % 26, cipher);
        load_start(0, 4, 21);
        repeat (4) type_key("notch_aev", $urandom % 26, cipher);

        // digit, space, enter, and break codes give nothing
        send_byte(8'h16);
        send_byte(8'h29);
        send_byte(8'h5A);
        send_byte(8'hF0);
        send_byte(8'h1C);
        repeat (20) @(negedge CLOCK_50);
        if (got_q.size() != 0) begin
            $display("filter: a byte that is not a letter make produced output");
            errors++;
        end
        check_positions("filter");
        type_key("after_filter", $urandom % 26, cipher);

        random_ready = 1'b1;
        repeat (40) type_key("backpressure", $urandom % 26, cipher);
        random_ready = 1'b0;
        repeat (20) @(negedge CLOCK_50);
        if (got_q.size() != 0) begin
            $display("backpressure: %0d extra output bytes after the last key", got_q.size());
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // run bound from the key count
    initial begin
        #(CLK_PERIOD * (TOTAL_KEYS * KEY_CYCLES + 400));
        $display("timeout: the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
+incdir+verif
verilog/enigma_pkg.sv
verilog/scan_decoder.sv
verilog/rotor_stepper.sv
verilog/rotor_path.sv
verilog/cipher_result.sv
verilog/enigma_top.sv
verif/tb_enigma.sv
